// File: src/scan_cfg.svh
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// frame layout, address field sits above the data field
`define SCAN_ADDR_W 12
`define SCAN_DATA_W 128
`define SCAN_FRAME_W 140

`define SCAN_CHAINS 11

// chain addresses as seen in the frame address field
`define SCAN_ADDR_FE_BIAS 12'd300
`define SCAN_ADDR_CP16G 12'd100
`define SCAN_ADDR_TNH1_CASC 12'd500
`define SCAN_ADDR_TNH2_CASC 12'd800
`define SCAN_ADDR_CP8G 12'd200
`define SCAN_ADDR_VTC 12'd1000
`define SCAN_ADDR_SF 12'd700
`define SCAN_ADDR_TNH2_BIAS 12'd900
`define SCAN_ADDR_HPF 12'd400
`define SCAN_ADDR_MISC 12'd1100
`define SCAN_ADDR_TNH1_BIAS 12'd600

// analog control field widths
`define BIAS8_W 8
`define CP_CTRL_W 6
`define BIAS2_W 2
`define AMUX_W 9
`define CLK_INV_W 16

// lane counts per chain type
`define LANES 16
`define HPF_LANES 8
`define CP16G_LANES 8

`endif

// File: src/scan_pkg.sv
`default_nettype none

`include "scan_cfg.svh"

package scan_pkg;

	// front end bias and common mode references, 32 bits
	typedef struct packed {
		logic [`BIAS8_W-1:0] hpf_biasn;
		logic [`BIAS8_W-1:0] hpf_biasp;
		logic [`BIAS8_W-1:0] ctle_cm_vref;
		logic [`BIAS8_W-1:0] abuf_cm_vref;
	} fe_bias_t;

	// 16G charge pump, 66 bits
	// ctrl[0] sits at the top, next to sel
	typedef struct packed {
		logic [`BIAS2_W-1:0] sel;
		logic [0:`CP16G_LANES-1][`CP_CTRL_W-1:0] ctrl;
		logic [`BIAS8_W-1:0] ctrln;
		logic [`BIAS8_W-1:0] ctrlp;
	} cp16g_t;

	// track and hold cascode bias, one byte per lane, 128 bits
	typedef struct packed {
		logic [0:`LANES-1][`BIAS8_W-1:0] lane;
	} casc_bias_t;

	// 8G charge pump, one control per lane, 96 bits
	typedef struct packed {
		logic [0:`LANES-1][`CP_CTRL_W-1:0] ctrl;
	} cp8g_t;

	// 2-bit per lane bias, shared by vtc, sf and both tnh stages
	typedef struct packed {
		logic [0:`LANES-1][`BIAS2_W-1:0] lane;
	} lane_bias2_t;

	// hpf bias, all biasn bytes above all biasp bytes
	typedef struct packed {
		logic [0:`HPF_LANES-1][`BIAS8_W-1:0] biasn;
		logic [0:`HPF_LANES-1][`BIAS8_W-1:0] biasp;
	} hpf_bias_t;

	// clocking and debug controls, 27 bits
	typedef struct packed {
		logic en_div_4to1;
		logic ringosc_en;
		logic [`AMUX_W-1:0] amux;
		logic [`CLK_INV_W-1:0] sel_clk_inv;
	} misc_ctrl_t;

	// full scan frame; the first bit shifted in lands in addr msb
	typedef struct packed {
		logic [`SCAN_ADDR_W-1:0] addr;
		logic [`SCAN_DATA_W-1:0] data;
	} scan_frame_t;

	// chain selected by an address
	// values double as the bit index into the load vector
	typedef enum logic [3:0] {
		CHAIN_FE_BIAS = 4'd0,
		CHAIN_CP16G = 4'd1,
		CHAIN_TNH1_CASC = 4'd2,
		CHAIN_TNH2_CASC = 4'd3,
		CHAIN_CP8G = 4'd4,
		CHAIN_VTC = 4'd5,
		CHAIN_SF = 4'd6,
		CHAIN_TNH2_BIAS = 4'd7,
		CHAIN_HPF = 4'd8,
		CHAIN_MISC = 4'd9,
		CHAIN_TNH1_BIAS = 4'd10,
		CHAIN_NONE = 4'd11
	} scan_chain_e;

endpackage

`default_nettype wire

// File: src/scan_shift_frame.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_cfg.svh"

module scan_shift_frame
	import scan_pkg::*;
(
	input  logic        scan_clk,
	input  logic        rst,
	input  logic        scan_en,
	input  logic        scan_in,
	output scan_frame_t frame,
	output logic        update,
	output logic        scan_out
);

	logic [`SCAN_FRAME_W-1:0] shift_q;
	logic scan_en_q;
	logic scan_en_qq;

	// new bits enter at bit 0, the oldest bit leaves at the top
	always_ff @(posedge scan_clk) begin
		if (rst) begin
			shift_q <= '0;
		end else if (scan_en) begin
			shift_q <= {shift_q[`SCAN_FRAME_W-2:0], scan_in};
		end
	end

	// two samples of scan_en so the falling edge decodes from flops only
	always_ff @(posedge scan_clk) begin
		if (rst) begin
			scan_en_q <= 1'b0;
			scan_en_qq <= 1'b0;
		end else begin
			scan_en_q <= scan_en;
			scan_en_qq <= scan_en_q;
		end
	end

	// one cycle wide, starts at the first edge that samples scan_en low
	assign update = scan_en_qq & ~scan_en_q;

	assign frame = scan_frame_t'(shift_q);

	assign scan_out = shift_q[`SCAN_FRAME_W-1];

endmodule

`default_nettype wire

// File: src/scan_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_cfg.svh"

module scan_addr_decode
	import scan_pkg::*;
(
	input  logic [`SCAN_ADDR_W-1:0] addr,
	input  logic                    update,
	output logic [`SCAN_CHAINS-1:0] load_en
);

	scan_chain_e chain;

	// address to chain lookup
	always_comb begin
		case (addr)
			`SCAN_ADDR_FE_BIAS:   chain = CHAIN_FE_BIAS;
			`SCAN_ADDR_CP16G:     chain = CHAIN_CP16G;
			`SCAN_ADDR_TNH1_CASC: chain = CHAIN_TNH1_CASC;
			`SCAN_ADDR_TNH2_CASC: chain = CHAIN_TNH2_CASC;
			`SCAN_ADDR_CP8G:      chain = CHAIN_CP8G;
			`SCAN_ADDR_VTC:       chain = CHAIN_VTC;
			`SCAN_ADDR_SF:        chain = CHAIN_SF;
			`SCAN_ADDR_TNH2_BIAS: chain = CHAIN_TNH2_BIAS;
			`SCAN_ADDR_HPF:       chain = CHAIN_HPF;
			`SCAN_ADDR_MISC:      chain = CHAIN_MISC;
			`SCAN_ADDR_TNH1_BIAS: chain = CHAIN_TNH1_BIAS;
			default:              chain = CHAIN_NONE;
		endcase
	end

	// one-hot load strobe, nothing for an unknown address
	always_comb begin
		load_en = '0;
		if (update && (chain != CHAIN_NONE)) begin
			load_en[chain] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/scan_cfg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_cfg.svh"

module scan_cfg_bank
	import scan_pkg::*;
(
	input  logic                    scan_clk,
	input  logic                    rst,
	input  logic [`SCAN_DATA_W-1:0] data,
	input  logic [`SCAN_CHAINS-1:0] load_en,
	output fe_bias_t                fe_bias,
	output cp16g_t                  cp16g,
	output casc_bias_t              tnh1_casc,
	output casc_bias_t              tnh2_casc,
	output cp8g_t                   cp8g,
	output lane_bias2_t             vtc_bias,
	output lane_bias2_t             sf_bias,
	output lane_bias2_t             tnh2_bias,
	output hpf_bias_t               hpf_bias,
	output misc_ctrl_t              misc_ctrl,
	output lane_bias2_t             tnh1_bias
);

	// power-up settings of the analog front end
	localparam fe_bias_t FE_BIAS_RST = '{
		hpf_biasn: 8'd175,
		hpf_biasp: 8'd175,
		ctle_cm_vref: 8'd175,
		abuf_cm_vref: 8'd163
	};

	localparam cp16g_t CP16G_RST = '{
		sel: 2'd2,
		ctrl: {6'd38, 6'd36, 6'd42, 6'd40, 6'd32, 6'd36, 6'd20, 6'd18},
		ctrln: 8'd0,
		ctrlp: 8'd255
	};

	localparam casc_bias_t TNH1_CASC_RST = '{lane: {`LANES{8'd165}}};
	localparam casc_bias_t TNH2_CASC_RST = '{lane: {`LANES{8'd128}}};

	// lane 0 first
	localparam cp8g_t CP8G_RST = '{
		ctrl: {6'd22, 6'd24, 6'd24, 6'd30, 6'd24, 6'd26, 6'd28, 6'd28,
			6'd26, 6'd26, 6'd26, 6'd26, 6'd18, 6'd26, 6'd26, 6'd28}
	};

	localparam lane_bias2_t LANE_BIAS2_RST = '{lane: '0};

	localparam hpf_bias_t HPF_RST = '{
		biasn: {`HPF_LANES{8'd179}},
		biasp: {`HPF_LANES{8'd179}}
	};

	localparam misc_ctrl_t MISC_RST = '{
		en_div_4to1: 1'b0,
		ringosc_en: 1'b0,
		amux: 9'd1,
		sel_clk_inv: 16'd0
	};

	// each chain keeps only its own width, taken from the low data bits
	always_ff @(posedge scan_clk) begin
		if (rst) begin
			fe_bias <= FE_BIAS_RST;
			cp16g <= CP16G_RST;
			tnh1_casc <= TNH1_CASC_RST;
			tnh2_casc <= TNH2_CASC_RST;
			cp8g <= CP8G_RST;
			vtc_bias <= LANE_BIAS2_RST;
			sf_bias <= LANE_BIAS2_RST;
			tnh2_bias <= LANE_BIAS2_RST;
			hpf_bias <= HPF_RST;
			misc_ctrl <= MISC_RST;
			tnh1_bias <= LANE_BIAS2_RST;
		end else begin
			if (load_en[CHAIN_FE_BIAS])
				fe_bias <= fe_bias_t'(data[$bits(fe_bias_t)-1:0]);
			if (load_en[CHAIN_CP16G])
				cp16g <= cp16g_t'(data[$bits(cp16g_t)-1:0]);
			if (load_en[CHAIN_TNH1_CASC])
				tnh1_casc <= casc_bias_t'(data[$bits(casc_bias_t)-1:0]);
			if (load_en[CHAIN_TNH2_CASC])
				tnh2_casc <= casc_bias_t'(data[$bits(casc_bias_t)-1:0]);
			if (load_en[CHAIN_CP8G])
				cp8g <= cp8g_t'(data[$bits(cp8g_t)-1:0]);
			if (load_en[CHAIN_VTC])
				vtc_bias <= lane_bias2_t'(data[$bits(lane_bias2_t)-1:0]);
			if (load_en[CHAIN_SF])
				sf_bias <= lane_bias2_t'(data[$bits(lane_bias2_t)-1:0]);
			if (load_en[CHAIN_TNH2_BIAS])
				tnh2_bias <= lane_bias2_t'(data[$bits(lane_bias2_t)-1:0]);
			if (load_en[CHAIN_HPF])
				hpf_bias <= hpf_bias_t'(data[$bits(hpf_bias_t)-1:0]);
			if (load_en[CHAIN_MISC])
				misc_ctrl <= misc_ctrl_t'(data[$bits(misc_ctrl_t)-1:0]);
			if (load_en[CHAIN_TNH1_BIAS])
				tnh1_bias <= lane_bias2_t'(data[$bits(lane_bias2_t)-1:0]);
		end
	end

endmodule

`default_nettype wire

// File: src/scan_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_cfg.svh"

module scan_top
	import scan_pkg::*;
(
	input  logic        scan_clk,
	input  logic        rst,
	input  logic        scan_en,
	input  logic        scan_in,
	output logic        scan_out,
	output fe_bias_t    fe_bias,
	output cp16g_t      cp16g,
	output casc_bias_t  tnh1_casc,
	output casc_bias_t  tnh2_casc,
	output cp8g_t       cp8g,
	output lane_bias2_t vtc_bias,
	output lane_bias2_t sf_bias,
	output lane_bias2_t tnh2_bias,
	output hpf_bias_t   hpf_bias,
	output misc_ctrl_t  misc_ctrl,
	output lane_bias2_t tnh1_bias
);

	scan_frame_t frame;
	logic update;
	logic [`SCAN_CHAINS-1:0] load_en;

	scan_shift_frame u_shift_frame (
		.scan_clk(scan_clk),
		.rst(rst),
		.scan_en(scan_en),
		.scan_in(scan_in),
		.frame(frame),
		.update(update),
		.scan_out(scan_out)
	);

	scan_addr_decode u_addr_decode (
		.addr(frame.addr),
		.update(update),
		.load_en(load_en)
	);

	// analog-facing configuration registers
	scan_cfg_bank u_cfg_bank (
		.scan_clk(scan_clk),
		.rst(rst),
		.data(frame.data),
		.load_en(load_en),
		.fe_bias(fe_bias),
		.cp16g(cp16g),
		.tnh1_casc(tnh1_casc),
		.tnh2_casc(tnh2_casc),
		.cp8g(cp8g),
		.vtc_bias(vtc_bias),
		.sf_bias(sf_bias),
		.tnh2_bias(tnh2_bias),
		.hpf_bias(hpf_bias),
		.misc_ctrl(misc_ctrl),
		.tnh1_bias(tnh1_bias)
	);

endmodule

`default_nettype wire

// File: testbench/scan_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_cfg.svh"

module scan_top_tb
	import scan_pkg::*;
();

	localparam int NUM_RECORDS = 20;
	localparam int TIMEOUT_CYCLES = NUM_RECORDS * 150 + 500;
	localparam int JUNK_BITS = 20;
	localparam logic [3:0] NO_CHAIN = 4'hf;

	logic scan_clk;
	logic rst;
	logic scan_en;
	logic scan_in;
	logic scan_out;
	fe_bias_t fe_bias;
	cp16g_t cp16g;
	casc_bias_t tnh1_casc;
	casc_bias_t tnh2_casc;
	cp8g_t cp8g;
	lane_bias2_t vtc_bias;
	lane_bias2_t sf_bias;
	lane_bias2_t tnh2_bias;
	hpf_bias_t hpf_bias;
	misc_ctrl_t misc_ctrl;
	lane_bias2_t tnh1_bias;

	// four words per record for address, data, chain index and expected value
	logic [127:0] golden_mem [0:4*NUM_RECORDS-1];
	logic [127:0] model_chain [0:`SCAN_CHAINS-1];
	// expected contents of the DUT shift register
	logic [`SCAN_FRAME_W-1:0] model_sr;
	int cycle_count = 0;

	scan_top UUT (
		.scan_clk(scan_clk),
		.rst(rst),
		.scan_en(scan_en),
		.scan_in(scan_in),
		.scan_out(scan_out),
		.fe_bias(fe_bias),
		.cp16g(cp16g),
		.tnh1_casc(tnh1_casc),
		.tnh2_casc(tnh2_casc),
		.cp8g(cp8g),
		.vtc_bias(vtc_bias),
		.sf_bias(sf_bias),
		.tnh2_bias(tnh2_bias),
		.hpf_bias(hpf_bias),
		.misc_ctrl(misc_ctrl),
		.tnh1_bias(tnh1_bias)
	);

	always #50 scan_clk = ~scan_clk;

	always @(posedge scan_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_on_error();
		end
	end

	// power-up values with the first field in the top bits
	function automatic logic [127:0] reset_value(input int idx);
		case (idx)
			0: reset_value = 128'({8'd175, 8'd175, 8'd175, 8'd163});
			1: reset_value = 128'({2'd2, 6'd38, 6'd36, 6'd42, 6'd40, 6'd32, 6'd36,
				6'd20, 6'd18, 8'd0, 8'd255});
			2: reset_value = {16{8'd165}};
			3: reset_value = {16{8'd128}};
			4: reset_value = 128'({6'd22, 6'd24, 6'd24, 6'd30, 6'd24, 6'd26, 6'd28, 6'd28,
				6'd26, 6'd26, 6'd26, 6'd26, 6'd18, 6'd26, 6'd26, 6'd28});
			8: reset_value = {16{8'd179}};
			9: reset_value = 128'({1'b0, 1'b0, 9'd1, 16'd0});
			default: reset_value = '0;
		endcase
	endfunction

	function automatic logic [127:0] chain_value(input int idx);
		case (idx)
			0: chain_value = 128'(fe_bias);
			1: chain_value = 128'(cp16g);
			2: chain_value = 128'(tnh1_casc);
			3: chain_value = 128'(tnh2_casc);
			4: chain_value = 128'(cp8g);
			5: chain_value = 128'(vtc_bias);
			6: chain_value = 128'(sf_bias);
			7: chain_value = 128'(tnh2_bias);
			8: chain_value = 128'(hpf_bias);
			9: chain_value = 128'(misc_ctrl);
			default: chain_value = 128'(tnh1_bias);
		endcase
	endfunction

	function automatic string chain_name(input int idx);
		case (idx)
			0: chain_name = "fe_bias";
			1: chain_name = "cp16g";
			2: chain_name = "tnh1_casc";
			3: chain_name = "tnh2_casc";
			4: chain_name = "cp8g";
			5: chain_name = "vtc_bias";
			6: chain_name = "sf_bias";
			7: chain_name = "tnh2_bias";
			8: chain_name = "hpf_bias";
			9: chain_name = "misc_ctrl";
			default: chain_name = "tnh1_bias";
		endcase
	endfunction

	task automatic stop_on_error();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_chains();
		for (int i = 0; i < `SCAN_CHAINS; i++) begin
			assert (chain_value(i) === model_chain[i]) else begin
				$display("Fail %s: got %h, expected %h", chain_name(i), chain_value(i),
					model_chain[i]);
				stop_on_error();
			end
		end
	endtask

	task automatic verify_scan_out();
		assert (scan_out === model_sr[`SCAN_FRAME_W-1]) else begin
			$display("Fail scan_out: got %h, expected %h", scan_out,
				model_sr[`SCAN_FRAME_W-1]);
			stop_on_error();
		end
	endtask

	// the bit driven here is shifted in on the next rising edge
	task automatic shift_bit(input logic bit_val);
		@(posedge scan_clk);
		scan_en <= 1'b1;
		scan_in <= bit_val;
		@(negedge scan_clk);
		verify_scan_out();
		check_chains();
		model_sr = {model_sr[`SCAN_FRAME_W-2:0], bit_val};
	endtask

	task automatic shift_frame(input logic [`SCAN_FRAME_W-1:0] frame_bits);
		for (int i = `SCAN_FRAME_W - 1; i >= 0; i--) begin
			shift_bit(frame_bits[i]);
		end
	endtask

	task automatic apply_update(input logic [3:0] chain_idx, input logic [127:0] expected);
		@(posedge scan_clk);
		scan_en <= 1'b0;
		@(negedge scan_clk);
		verify_scan_out();
		check_chains();
		// the chain must still hold after the first edge with scan_en low
		@(posedge scan_clk);
		@(negedge scan_clk);
		check_chains();
		@(posedge scan_clk);
		@(negedge scan_clk);
		if (chain_idx != NO_CHAIN) begin
			model_chain[chain_idx] = expected;
		end
		verify_scan_out();
		check_chains();
	endtask

	task automatic load_golden();
		for (int i = 0; i < 4 * NUM_RECORDS; i++) begin
			golden_mem[i] = {4{~i}};
		end
		$readmemh("testbench/scan_golden.txt", golden_mem);
		for (int r = 0; r < NUM_RECORDS; r++) begin
			assert (golden_mem[4*r] < 128'd4096 && (golden_mem[4*r+2] < `SCAN_CHAINS ||
				golden_mem[4*r+2] == 128'(NO_CHAIN))) else begin
				$display("golden file record %0d is missing or malformed", r);
				stop_on_error();
			end
		end
	endtask

	task automatic run_golden_records();
		logic [`SCAN_ADDR_W-1:0] addr;
		logic [`SCAN_DATA_W-1:0] data;
		for (int r = 0; r < NUM_RECORDS; r++) begin
			addr = golden_mem[4*r][`SCAN_ADDR_W-1:0];
			data = golden_mem[4*r+1];
			shift_frame({addr, data});
			apply_update(golden_mem[4*r+2][3:0], golden_mem[4*r+3]);
		end
	endtask

	// the previous frame must come out on scan_out while a random one goes in
	task automatic pass_through_random();
		logic [`SCAN_ADDR_W-1:0] addr;
		logic [`SCAN_DATA_W-1:0] data;
		// chain addresses are all even, so an odd one selects nothing
		addr = `SCAN_ADDR_W'($urandom()) | `SCAN_ADDR_W'(1);
		data = {$urandom(), $urandom(), $urandom(), $urandom()};
		shift_frame({addr, data});
		apply_update(NO_CHAIN, '0);
	endtask

	// more than a frame of edges where only the last 140 bits count
	task automatic long_shift_replay();
		logic [JUNK_BITS-1:0] junk;
		junk = JUNK_BITS'($urandom());
		for (int i = JUNK_BITS - 1; i >= 0; i--) begin
			shift_bit(junk[i]);
		end
		shift_frame({golden_mem[0][`SCAN_ADDR_W-1:0], golden_mem[1]});
		apply_update(golden_mem[2][3:0], golden_mem[3]);
	endtask

	initial begin
		scan_clk = 1'b0;
		rst = 1'b1;
		scan_en = 1'b0;
		scan_in = 1'b0;
		model_sr = '0;
		void'($urandom(32'hfb9a));
		for (int i = 0; i < `SCAN_CHAINS; i++) begin
			model_chain[i] = reset_value(i);
		end
		load_golden();

		repeat (16) @(posedge scan_clk);
		rst <= 1'b0;
		@(negedge scan_clk);
		verify_scan_out();
		check_chains();

		run_golden_records();
		pass_through_random();
		long_shift_replay();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/scan_pkg.sv
src/scan_shift_frame.sv
src/scan_addr_decode.sv
src/scan_cfg_bank.sv
src/scan_top.sv
testbench/scan_top_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the scan block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
	-f flist.f \
	--top-module scan_top_tb \
	--Mdir obj_dir \
	-o scan_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_output=$(./obj_dir/scan_top_tb_sim)
status=$?
printf '%s\n' "$sim_output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/scan_golden.txt
// hex fields per record: chain address, 128-bit frame data, chain index (f when no chain
// matches), expected chain output zero-extended to 128 bits
12c 111111112222222233333333c0a1b2e4 0 000000000000000000000000c0a1b2e4
064 deadbeef0123456789abcdef0f1e2d3c 1 000000000000000389abcdef0f1e2d3c
1f4 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 2 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
320 00112233445566778899aabbccddeeff 3 00112233445566778899aabbccddeeff
0c8 ffffffff123456789abcdef013579bdf 4 00000000123456789abcdef013579bdf
3e8 876543210fedcba9ffff0000e4e41b1b 5 000000000000000000000000e4e41b1b
2bc 0000000000000000abcdabcd55aa33cc 6 00000000000000000000000055aa33cc
384 1212121234343434565656569c9c9c9c 7 0000000000000000000000009c9c9c9c
190 b3b3b3b3b3b3b3b31a2b3c4d5e6f7081 8 b3b3b3b3b3b3b3b31a2b3c4d5e6f7081
44c ffffffffffffffffffffffffffffffff 9 00000000000000000000000007ffffff
258 0badc0de0badc0de0badc0de76543210 a 00000000000000000000000076543210
12d ffffffffffffffffffffffffffffffff f 00000000000000000000000000000000
12c cafef00dcafef00dcafef00d5a5a0ff0 0 0000000000000000000000005a5a0ff0
44c 0000000000000000123456780abcdef1 9 00000000000000000000000002bcdef1
064 00000000fffffffe0000000000000001 1 00000000000000020000000000000001
7ff 0123456789abcdef0123456789abcdef f 00000000000000000000000000000000
0c8 55555555aaaaaaaa55555555aaaaaaaa 4 00000000aaaaaaaa55555555aaaaaaaa
190 00000000000000000000000000000000 8 00000000000000000000000000000000
320 808080807f7f7f7f01010101fefefefe 3 808080807f7f7f7f01010101fefefefe
2bc 12345678123456781234567800000003 6 00000000000000000000000000000003
